// File: include/qu_defs.svh
// Back-end sizing: station, reorder buffer, stage FIFOs and datapath widths
`ifndef QU_DEFS_SVH
`define QU_DEFS_SVH

// Reservation station and reorder buffer entries
`define QU_RS_DEPTH   8
`define QU_ROB_DEPTH  8

// Depth of each stage FIFO
`define QU_FIFO_DEPTH 4

// Scheduler window size, one station read port per slot
`define QU_RD_PORTS   4

// Datapath
`define QU_DATA_W     32
`define QU_PHY_ADDR_W 6

`endif

// File: rtl/qu_pkg.sv
// Back-end types for ALU opcodes, buffer indices, micro-ops and results
`default_nettype none

`include "qu_defs.svh"

package qu_pkg;

    // Shifts take the low bits of operand 2, SLT is signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    typedef logic [$clog2(`QU_ROB_DEPTH)-1:0] rob_addr_t;
    typedef logic [$clog2(`QU_RS_DEPTH)-1:0]  res_st_addr_t;
    typedef logic [`QU_PHY_ADDR_W-1:0]        phy_rf_addr_t;
    typedef logic [`QU_DATA_W-1:0]            phy_rf_data_t;

    // Either a value (ready) or the ROB tag of its producer
    typedef struct packed {
        logic         ready;
        rob_addr_t    tag;
        phy_rf_data_t value;
    } operand_t;

    typedef struct packed {
        logic         valid;
        alu_op_e      op;
        phy_rf_addr_t dest;
        rob_addr_t    rob_addr;
        operand_t     src1;
        operand_t     src2;
    } res_st_cell_t;

    typedef struct packed {
        rob_addr_t    rob_addr;
        phy_rf_data_t value;
    } exec_result_t;

endpackage

`default_nettype wire

// File: rtl/res_st_rd_if.sv
// Scheduler read and issue-clear link into the reservation station
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

interface res_st_rd_if import qu_pkg::*; ();

    // Combinational window reads
    res_st_addr_t rd_addr [`QU_RD_PORTS];
    res_st_cell_t rd_cell [`QU_RD_PORTS];

    // Frees the issued entry at the next edge
    logic         clr_en;
    res_st_addr_t clr_addr;

    modport sched (
        output rd_addr,
        output clr_en,
        output clr_addr,
        input  rd_cell
    );

    modport station (
        input  rd_addr,
        input  clr_en,
        input  clr_addr,
        output rd_cell
    );

endinterface

`default_nettype wire

// File: rtl/res_station.sv
// Reservation station holding dispatched micro-ops until their operands resolve
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

module res_station import qu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         dispatch_en,
    input  res_st_cell_t dispatch_cell,
    input  logic         commit_en,
    input  rob_addr_t    commit_rob_addr,
    input  phy_rf_data_t commit_value,
    res_st_rd_if.station rd,
    output logic         full
);

    logic [`QU_RS_DEPTH-1:0] valid_q;
    res_st_cell_t            cells_q [`QU_RS_DEPTH];
    res_st_cell_t            disp_cell;
    res_st_addr_t            free_idx;
    logic                    do_dispatch;

    // Capture the broadcast value if the operand waits on the committing tag
    function automatic operand_t wake(operand_t opnd);
        operand_t res;
        res = opnd;
        if (commit_en && !opnd.ready && opnd.tag == commit_rob_addr) begin
            res.ready = 1'b1;
            res.value = commit_value;
        end
        return res;
    endfunction

    assign full        = &valid_q;
    assign do_dispatch = dispatch_en && !full;

    // Lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = `QU_RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = res_st_addr_t'(i);
            end
        end
    end

    // Same-cycle bypass for operands whose producer commits right now
    always_comb begin
        disp_cell      = dispatch_cell;
        disp_cell.src1 = wake(dispatch_cell.src1);
        disp_cell.src2 = wake(dispatch_cell.src2);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `QU_RS_DEPTH; i++) begin
            if (do_dispatch && free_idx == res_st_addr_t'(i)) begin
                cells_q[i] <= disp_cell;
            end else begin
                cells_q[i].src1 <= wake(cells_q[i].src1);
                cells_q[i].src2 <= wake(cells_q[i].src2);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (rd.clr_en) begin
                valid_q[rd.clr_addr] <= 1'b0;
            end
            if (do_dispatch) begin
                valid_q[free_idx] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `QU_RD_PORTS; p++) begin
            rd.rd_cell[p]       = cells_q[rd.rd_addr[p]];
            rd.rd_cell[p].valid = valid_q[rd.rd_addr[p]];
        end
    end

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_en |-> !full);

    // Scheduler may only free a live entry
    a_clear_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd.clr_en |-> valid_q[rd.clr_addr]);

endmodule

`default_nettype wire

// File: rtl/schedule.sv
// Scheduler picking one ready micro-op per cycle from an alternating window
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

module schedule import qu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,
    input  logic         fifo_full,
    res_st_rd_if.sched   rs,
    output logic         fifo_wr_en,
    output res_st_cell_t op_out
);

    localparam int PICK_W = $clog2(`QU_RD_PORTS);

    res_st_addr_t      base_q;
    logic [PICK_W-1:0] pick;
    logic              found;
    logic              issue;

    // Window base steps 0, 4, 0, ... on enabled cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q <= '0;
        end else if (en) begin
            base_q <= base_q + res_st_addr_t'(`QU_RD_PORTS);
        end
    end

    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int p = `QU_RD_PORTS - 1; p >= 0; p--) begin
            rs.rd_addr[p] = base_q + res_st_addr_t'(p);
            if (rs.rd_cell[p].valid && rs.rd_cell[p].src1.ready &&
                rs.rd_cell[p].src2.ready) begin
                found = 1'b1;
                pick  = PICK_W'(p);
            end
        end
    end

    assign issue       = en && !fifo_full && found;
    assign fifo_wr_en  = issue;
    assign op_out      = rs.rd_cell[pick];
    assign rs.clr_en   = issue;
    assign rs.clr_addr = rs.rd_addr[pick];

endmodule

`default_nettype wire

// File: rtl/qu_fifo.sv
// Synchronous stage FIFO with the head word visible on the output
`default_nettype none
`timescale 1ns/1ps

module qu_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] data_in,
    input  logic             rd_en,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr    = wr_en && !full;
    assign do_rd    = rd_en && !empty;
    assign empty    = count == '0;
    assign full     = count == CNT_W'(DEPTH);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty);

endmodule

`default_nettype wire

// File: rtl/execute.sv
// Combinational ALU moving one micro-op per cycle from FIFO 1 to FIFO 2
`default_nettype none
`timescale 1ns/1ps

module execute import qu_pkg::*; (
    input  res_st_cell_t op_in,
    input  logic         in_valid,
    input  logic         out_full,
    output logic         in_rd_en,
    output logic         out_wr_en,
    output exec_result_t result
);

    localparam int SHAMT_W = $clog2($bits(phy_rf_data_t));

    phy_rf_data_t       a;
    phy_rf_data_t       b;
    logic [SHAMT_W-1:0] shamt;

    assign a     = op_in.src1.value;
    assign b     = op_in.src2.value;
    assign shamt = b[SHAMT_W-1:0];

    // Pop and push together
    assign in_rd_en  = in_valid && !out_full;
    assign out_wr_en = in_rd_en;

    always_comb begin
        result.rob_addr = op_in.rob_addr;
        case (op_in.op)
            ADD:     result.value = a + b;
            SUB:     result.value = a - b;
            AND:     result.value = a & b;
            OR:      result.value = a | b;
            XOR:     result.value = a ^ b;
            SLL:     result.value = a << shamt;
            SRL:     result.value = a >> shamt;
            SLT:     result.value = phy_rf_data_t'($signed(a) < $signed(b));
            default: result.value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/retire.sv
// Reorder buffer allocating at dispatch and committing results in program order
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

module retire import qu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         alloc_en,
    input  phy_rf_addr_t alloc_dest,
    input  logic         res_valid,
    input  exec_result_t res_in,
    output logic         res_rd_en,
    output rob_addr_t    rob_tail_ptr,
    output logic         rob_full,
    output logic         commit_en,
    output rob_addr_t    commit_rob_addr,
    output phy_rf_addr_t commit_phy_addr,
    output phy_rf_data_t commit_value
);

    localparam int CNT_W = $clog2(`QU_ROB_DEPTH + 1);

    logic [`QU_ROB_DEPTH-1:0] busy_q;
    logic [`QU_ROB_DEPTH-1:0] done_q;
    phy_rf_addr_t             dest_q  [`QU_ROB_DEPTH];
    phy_rf_data_t             value_q [`QU_ROB_DEPTH];
    rob_addr_t                head_q;
    rob_addr_t                tail_q;
    logic [CNT_W-1:0]         count_q;
    logic                     do_alloc;

    assign do_alloc     = alloc_en && !rob_full;
    assign rob_tail_ptr = tail_q;
    assign rob_full     = count_q == CNT_W'(`QU_ROB_DEPTH);

    // Every result already owns a slot
    assign res_rd_en = res_valid;

    // Head commits the cycle after its result lands
    assign commit_en       = busy_q[head_q] && done_q[head_q];
    assign commit_rob_addr = head_q;
    assign commit_phy_addr = dest_q[head_q];
    assign commit_value    = value_q[head_q];

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            dest_q[tail_q] <= alloc_dest;
        end
        if (res_valid) begin
            value_q[res_in.rob_addr] <= res_in.value;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (res_valid) begin
                done_q[res_in.rob_addr] <= 1'b1;
            end
            if (commit_en) begin
                busy_q[head_q] <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (do_alloc) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_alloc) - CNT_W'(commit_en);
        end
    end

    // A result must land on an allocated, still pending slot
    a_result_busy: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> busy_q[res_in.rob_addr] && !done_q[res_in.rob_addr]);

endmodule

`default_nettype wire

// File: rtl/back_end.sv
// Back-end top joining station, scheduler, ALU, stage FIFOs and reorder buffer
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

module back_end import qu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         schedule_en,

    input  logic         dispatch_en,
    input  alu_op_e      dispatch_op,
    input  phy_rf_addr_t dispatch_dest,
    input  logic         src1_ready,
    input  rob_addr_t    src1_tag,
    input  phy_rf_data_t src1_value,
    input  logic         src2_ready,
    input  rob_addr_t    src2_tag,
    input  phy_rf_data_t src2_value,

    output rob_addr_t    rob_tail_ptr,
    output logic         rob_full,
    output logic         res_st_full,
    output logic         commit_en,
    output rob_addr_t    commit_rob_addr,
    output phy_rf_addr_t commit_phy_addr,
    output phy_rf_data_t commit_value
);

    res_st_cell_t dispatch_cell;
    logic         dispatch_ok;

    logic         sched_wr_en;
    res_st_cell_t sched_op;
    logic         fifo1_empty;
    logic         fifo1_full;
    logic         fifo1_rd_en;
    res_st_cell_t exec_op;

    logic         exec_wr_en;
    exec_result_t exec_res;
    logic         fifo2_empty;
    logic         fifo2_full;
    logic         fifo2_rd_en;
    exec_result_t ret_res;

    // Accepted only with room in both station and ROB
    assign dispatch_ok = dispatch_en && !res_st_full && !rob_full;

    always_comb begin
        dispatch_cell.valid      = 1'b1;
        dispatch_cell.op         = dispatch_op;
        dispatch_cell.dest       = dispatch_dest;
        dispatch_cell.rob_addr   = rob_tail_ptr;
        dispatch_cell.src1.ready = src1_ready;
        dispatch_cell.src1.tag   = src1_tag;
        dispatch_cell.src1.value = src1_value;
        dispatch_cell.src2.ready = src2_ready;
        dispatch_cell.src2.tag   = src2_tag;
        dispatch_cell.src2.value = src2_value;
    end

    res_st_rd_if u_rd_if ();

    // Station applies its own full test on top of the ROB one
    res_station u_res_station (
        .clk             (clk),
        .rst_n           (rst_n),
        .dispatch_en     (dispatch_en && !rob_full),
        .dispatch_cell   (dispatch_cell),
        .commit_en       (commit_en),
        .commit_rob_addr (commit_rob_addr),
        .commit_value    (commit_value),
        .rd              (u_rd_if.station),
        .full            (res_st_full)
    );

    schedule u_schedule (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (schedule_en),
        .fifo_full  (fifo1_full),
        .rs         (u_rd_if.sched),
        .fifo_wr_en (sched_wr_en),
        .op_out     (sched_op)
    );

    qu_fifo #(
        .WIDTH ($bits(res_st_cell_t)),
        .DEPTH (`QU_FIFO_DEPTH)
    ) u_fifo_sched_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (sched_wr_en),
        .data_in  (sched_op),
        .rd_en    (fifo1_rd_en),
        .data_out (exec_op),
        .empty    (fifo1_empty),
        .full     (fifo1_full)
    );

    execute u_execute (
        .op_in     (exec_op),
        .in_valid  (!fifo1_empty),
        .out_full  (fifo2_full),
        .in_rd_en  (fifo1_rd_en),
        .out_wr_en (exec_wr_en),
        .result    (exec_res)
    );

    qu_fifo #(
        .WIDTH ($bits(exec_result_t)),
        .DEPTH (`QU_FIFO_DEPTH)
    ) u_fifo_exec_ret (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (exec_wr_en),
        .data_in  (exec_res),
        .rd_en    (fifo2_rd_en),
        .data_out (ret_res),
        .empty    (fifo2_empty),
        .full     (fifo2_full)
    );

    retire u_retire (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_en        (dispatch_ok),
        .alloc_dest      (dispatch_dest),
        .res_valid       (!fifo2_empty),
        .res_in          (ret_res),
        .res_rd_en       (fifo2_rd_en),
        .rob_tail_ptr    (rob_tail_ptr),
        .rob_full        (rob_full),
        .commit_en       (commit_en),
        .commit_rob_addr (commit_rob_addr),
        .commit_phy_addr (commit_phy_addr),
        .commit_value    (commit_value)
    );

    a_no_dispatch_rob_full: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_en |-> !rob_full);

endmodule

`default_nettype wire

// File: verification/tb_checks.svh
// Testbench helpers for typed result compares and the LCG random source
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Low LCG bits cycle quickly, so draw from the upper ones
function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return {8'd0, r[31:8]} % n;
endfunction

function automatic phy_rf_data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
endfunction

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run aborted");
endtask

task automatic check_rob_addr(input string name, input rob_addr_t act, input rob_addr_t exp);
    if (act !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
        $display("TB FAILED");
        $fatal(1, "ROB address mismatch");
    end
endtask

task automatic check_phy_addr(input string name, input phy_rf_addr_t act,
                              input phy_rf_addr_t exp);
    if (act !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
        $display("TB FAILED");
        $fatal(1, "physical address mismatch");
    end
endtask

task automatic check_value(input string name, input phy_rf_data_t act,
                           input phy_rf_data_t exp);
    if (act !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
        $display("TB FAILED");
        $fatal(1, "data mismatch");
    end
endtask

task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
        $display("TB FAILED");
        $fatal(1, "flag mismatch");
    end
endtask

`endif

// File: verification/tb_back_end.sv
// Back-end testbench with random dispatch and an in-order commit model
`default_nettype none
`timescale 1ns/1ps

`include "qu_defs.svh"

module tb_back_end import qu_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int N_ATTEMPTS  = 300;
    localparam int WATCHDOG_NS = N_ATTEMPTS * 40 * CLK_PERIOD;
    localparam int MSB         = `QU_DATA_W - 1;

    typedef struct packed {
        rob_addr_t    rob;
        phy_rf_addr_t dest;
        phy_rf_data_t value;
    } commit_exp_t;

    logic         clk;
    logic         rst_n;
    logic         schedule_en;
    logic         dispatch_en;
    alu_op_e      dispatch_op;
    phy_rf_addr_t dispatch_dest;
    logic         src1_ready;
    rob_addr_t    src1_tag;
    phy_rf_data_t src1_value;
    logic         src2_ready;
    rob_addr_t    src2_tag;
    phy_rf_data_t src2_value;
    rob_addr_t    rob_tail_ptr;
    logic         rob_full;
    logic         res_st_full;
    logic         commit_en;
    rob_addr_t    commit_rob_addr;
    phy_rf_addr_t commit_phy_addr;
    phy_rf_data_t commit_value;

    // Model state, updated at the falling edge
    logic [31:0]              lcg_state;
    commit_exp_t              exp_q [$];
    logic [`QU_ROB_DEPTH-1:0] in_flight;
    phy_rf_data_t             prod_value [`QU_ROB_DEPTH];
    int                       n_dispatched;
    int                       n_committed;

    `include "tb_checks.svh"

    back_end u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .schedule_en     (schedule_en),
        .dispatch_en     (dispatch_en),
        .dispatch_op     (dispatch_op),
        .dispatch_dest   (dispatch_dest),
        .src1_ready      (src1_ready),
        .src1_tag        (src1_tag),
        .src1_value      (src1_value),
        .src2_ready      (src2_ready),
        .src2_tag        (src2_tag),
        .src2_value      (src2_value),
        .rob_tail_ptr    (rob_tail_ptr),
        .rob_full        (rob_full),
        .res_st_full     (res_st_full),
        .commit_en       (commit_en),
        .commit_rob_addr (commit_rob_addr),
        .commit_phy_addr (commit_phy_addr),
        .commit_value    (commit_value)
    );

    function automatic phy_rf_data_t alu_model(input alu_op_e op, input phy_rf_data_t a,
                                               input phy_rf_data_t b);
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLL: return a << b[4:0];
            SRL: return a >> b[4:0];
            // Differing signs decide on their own
            SLT: begin
                if (a[MSB] != b[MSB]) begin
                    return phy_rf_data_t'(a[MSB]);
                end
                return phy_rf_data_t'(a < b);
            end
            default: return '0;
        endcase
    endfunction

    // Tag a source only while its producer has not been seen committing
    task automatic pick_source(input logic allow_tags, output logic ready,
                               output rob_addr_t tag, output phy_rf_data_t value);
        rob_addr_t cand;
        cand  = rob_addr_t'(rand_below(`QU_ROB_DEPTH));
        value = rand_word();
        tag   = cand;
        ready = !(allow_tags && in_flight[cand] && rand_below(2) == 0);
    endtask

    task automatic drive_dispatch(input logic want, input logic allow_tags);
        if (want && !rob_full && !res_st_full) begin
            dispatch_en   = 1'b1;
            dispatch_op   = alu_op_e'(3'(rand_below(8)));
            dispatch_dest = phy_rf_addr_t'(rand_below(1 << `QU_PHY_ADDR_W));
            pick_source(allow_tags, src1_ready, src1_tag, src1_value);
            pick_source(allow_tags, src2_ready, src2_tag, src2_value);
        end else begin
            dispatch_en = 1'b0;
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        #DRIVE_DELAY;
        dispatch_en = 1'b0;
        schedule_en = 1'b1;
        while (n_committed != n_dispatched) begin
            @(posedge clk);
        end
    endtask

    // Scheduler held off so eight micro-ops pile up in the station
    task automatic fill_station();
        @(posedge clk);
        #DRIVE_DELAY;
        schedule_en = 1'b0;
        for (int k = 0; k < `QU_RS_DEPTH; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_flag("res_st_full", res_st_full, 1'b0);
            drive_dispatch(1'b1, 1'b0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        dispatch_en = 1'b0;
        check_flag("res_st_full", res_st_full, 1'b1);
        check_flag("rob_full", rob_full, 1'b1);
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        check_flag("res_st_full", res_st_full, 1'b1);
        schedule_en = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_flag("res_st_full", res_st_full, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        commit_exp_t  head_exp;
        commit_exp_t  new_exp;
        phy_rf_data_t opa;
        phy_rf_data_t opb;
        if (rst_n) begin
            check_flag("rob_full", rob_full, (n_dispatched - n_committed) == `QU_ROB_DEPTH);
            if (commit_en) begin
                if (exp_q.size() == 0) begin
                    abort_run("Commit seen with no micro-op in flight");
                end else begin
                    head_exp = exp_q.pop_front();
                    check_rob_addr("commit_rob_addr", commit_rob_addr, head_exp.rob);
                    check_phy_addr("commit_phy_addr", commit_phy_addr, head_exp.dest);
                    check_value("commit_value", commit_value, head_exp.value);
                    in_flight[head_exp.rob] = 1'b0;
                    n_committed++;
                end
            end
            if (dispatch_en) begin
                // Value stays readable for a consumer dispatched in the commit cycle
                opa = src1_ready ? src1_value : prod_value[src1_tag];
                opb = src2_ready ? src2_value : prod_value[src2_tag];
                new_exp.rob   = rob_addr_t'(n_dispatched);
                new_exp.dest  = dispatch_dest;
                new_exp.value = alu_model(dispatch_op, opa, opb);
                check_rob_addr("rob_tail_ptr", rob_tail_ptr, new_exp.rob);
                prod_value[new_exp.rob] = new_exp.value;
                in_flight[new_exp.rob]  = 1'b1;
                exp_q.push_back(new_exp);
                n_dispatched++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: commits stopped before all micro-ops retired");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n         = 1'b0;
        schedule_en   = 1'b0;
        dispatch_en   = 1'b0;
        dispatch_op   = ADD;
        dispatch_dest = '0;
        src1_ready    = 1'b1;
        src1_tag      = '0;
        src1_value    = '0;
        src2_ready    = 1'b1;
        src2_tag      = '0;
        src2_value    = '0;
        lcg_state     = 32'd23;
        in_flight     = '0;
        n_dispatched  = 0;
        n_committed   = 0;

        repeat (4) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_flag("commit_en", commit_en, 1'b0);
        check_flag("rob_full", rob_full, 1'b0);
        check_flag("res_st_full", res_st_full, 1'b0);
        check_rob_addr("rob_tail_ptr", rob_tail_ptr, '0);

        for (int i = 0; i < N_ATTEMPTS; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            schedule_en = rand_below(10) < 8;
            drive_dispatch(rand_below(10) < 7, 1'b1);
        end
        wait_drained();

        fill_station();
        wait_drained();
        repeat (5) @(posedge clk);

        if (n_dispatched > 0 && n_committed == n_dispatched && exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Dispatched %0d micro-ops but committed %0d", n_dispatched, n_committed);
            $display("TB FAILED");
            $fatal(1, "commit count mismatch");
        end
    end

endmodule

`default_nettype wire

// File: qu_back_end.f
+incdir+include
+incdir+verification
rtl/qu_pkg.sv
rtl/res_st_rd_if.sv
rtl/res_station.sv
rtl/schedule.sv
rtl/qu_fifo.sv
rtl/execute.sv
rtl/retire.sv
rtl/back_end.sv
verification/tb_back_end.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the back-end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_back_end \
    -f qu_back_end.f \
    -o tb_back_end_sim

./obj_dir/tb_back_end_sim 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
